// File: sim/rsStim.txt
# I op v1 v2 q1 q2 imm pc tag expected latency (hex fields, latency decimal, 0 = any)
# F flushes the cluster; D waits until every outstanding tag has returned.
# Each opcode on independent operands, one lone ready instruction per cycle.
I 0 00000005 00000007 0 0 00000000 00000000 1 0000000c 2
I 1 00000003 00000005 0 0 00000000 00000000 2 fffffffe 2
I 2 f0f0f0f0 0ff00ff0 0 0 00000000 00000000 3 00f000f0 2
I 3 12340000 00005678 0 0 00000000 00000000 4 12345678 2
I 4 aaaaaaaa ffff0000 0 0 00000000 00000000 5 5555aaaa 2
I 5 00000001 00000024 0 0 00000000 00000000 6 00000010 2
I 6 80000000 0000001f 0 0 00000000 00000000 7 00000001 2
I 7 fffffffe 00000001 0 0 00000000 00000000 8 00000001 2
I 7 00000005 fffffff0 0 0 00000000 00000000 9 00000000 2
I 8 00001000 deadbeef 0 0 fffffffc 00000000 a 00000ffc 2
I 9 11111111 22222222 0 0 00001000 00400000 b 00401000 2
I f 12345678 00000001 0 0 00000000 00000000 c 00000000 2
D
# Dependency chains resolved by wakeup.
# Tag 3 waits on tag 2 for both operands.
I 0 00000010 00000020 0 0 00000000 00000000 1 00000030 2
I 1 00000000 00000008 1 0 00000000 00000000 2 00000028 0
I 0 00000000 00000000 2 2 00000000 00000000 3 00000050 0
I 4 ffffffff 00000000 0 3 00000000 00000000 4 ffffffaf 0
I 5 00000000 00000004 3 0 00000000 00000000 5 00000500 0
I 7 00000000 00000000 4 0 00000000 00000000 6 00000001 0
I 8 00000000 00000000 6 0 00000010 00000000 7 00000011 0
I 3 00000000 00000000 5 7 00000000 00000000 8 00000511 0
D
# Back-pressure. A short chain delays tag 4,
# and tags 5 to c wait on it until the station is full.
I 0 00000001 00000002 0 0 00000000 00000000 1 00000003 2
I 0 00000000 00000001 1 0 00000000 00000000 2 00000004 0
I 0 00000000 00000001 2 0 00000000 00000000 3 00000005 0
I 0 00000000 00000001 3 0 00000000 00000000 4 00000006 0
I 0 00000000 00000010 4 0 00000000 00000000 5 00000016 0
I 1 00000000 00000001 4 0 00000000 00000000 6 00000005 0
I 5 00000000 00000002 4 0 00000000 00000000 7 00000018 0
I 4 00000000 000000ff 4 0 00000000 00000000 8 000000f9 0
I 0 00000000 00000000 4 4 00000000 00000000 9 0000000c 0
I 2 00000000 00000002 4 0 00000000 00000000 a 00000002 0
I 3 00000100 00000000 0 4 00000000 00000000 b 00000106 0
I 8 00000000 00000000 4 0 00000200 00000000 c 00000206 0
# Ninth dependent, issued once a slot frees up.
I 1 00000000 00000006 c 0 00000000 00000000 d 00000200 0
D
# Flush. Tags 3 and 4 wait on tag e, tag 5 is about to be selected.
I 0 00000000 00000001 e 0 00000000 00000000 3 00000000 0
I 0 00000000 00000000 3 3 00000000 00000000 4 00000000 0
I 0 00000001 00000001 0 0 00000000 00000000 5 00000002 0
F
# Same tags again after the flush.
I 0 00000007 00000008 0 0 00000000 00000000 3 0000000f 2
I 1 00000000 00000005 3 0 00000000 00000000 4 0000000a 0
I 6 ffffffff 00000004 0 0 00000000 00000000 5 0fffffff 0
D

// File: filelist.f
design/rsPkg.sv
design/rsStation.sv
design/intAlu.sv
design/execCluster.sv
sim/tbClock.sv
sim/tbExecCluster.sv

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator and run it from the project root.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tbExecCluster \
    -f filelist.f \
    -o simExecCluster

./obj_dir/simExecCluster

// File: sim/tbExecCluster.sv
`timescale 1ns/1ps

module tbExecCluster;

    localparam int TagCount = 1 << rsPkg::TagWidth;
    localparam int WaitLimit = 200;

    logic clk;
    logic rstN;
    logic flush;
    logic issueValid;
    logic [rsPkg::OpWidth-1:0] issueOp;
    logic [rsPkg::DataWidth-1:0] issueV1;
    logic [rsPkg::DataWidth-1:0] issueV2;
    logic [rsPkg::TagWidth-1:0] issueQ1;
    logic [rsPkg::TagWidth-1:0] issueQ2;
    logic [rsPkg::DataWidth-1:0] issueImm;
    logic [rsPkg::DataWidth-1:0] issuePc;
    logic [rsPkg::TagWidth-1:0] issueTag;
    logic rsFull;
    logic resultValid;
    logic [rsPkg::TagWidth-1:0] resultTag;
    logic [rsPkg::DataWidth-1:0] resultData;

    // One stim record.
    logic [rsPkg::OpWidth-1:0] recOp;
    logic [rsPkg::DataWidth-1:0] recV1;
    logic [rsPkg::DataWidth-1:0] recV2;
    logic [rsPkg::TagWidth-1:0] recQ1;
    logic [rsPkg::TagWidth-1:0] recQ2;
    logic [rsPkg::DataWidth-1:0] recImm;
    logic [rsPkg::DataWidth-1:0] recPc;
    logic [rsPkg::TagWidth-1:0] recTag;
    logic [rsPkg::DataWidth-1:0] recExp;
    int recLat;

    // Expectation handed to the monitor with the issue strobe.
    logic [rsPkg::DataWidth-1:0] pendExp;
    int pendLat;

    // Scoreboard by tag.
    logic [TagCount-1:0] outstanding = '0;
    logic [TagCount-1:0] cancelled = '0;
    logic [rsPkg::DataWidth-1:0] expData [TagCount];
    int expLat [TagCount];
    int issueCycle [TagCount];
    int outstandingCount = 0;
    logic sawFull = 1'b0;
    int cycleCount = 0;

    tbClock u_tbClock (
        .clk (clk),
        .rstN(rstN)
    );

    execCluster u_execCluster (
        .clk        (clk),
        .rstN       (rstN),
        .flush      (flush),
        .issueValid (issueValid),
        .issueOp    (issueOp),
        .issueV1    (issueV1),
        .issueV2    (issueV2),
        .issueQ1    (issueQ1),
        .issueQ2    (issueQ2),
        .issueImm   (issueImm),
        .issuePc    (issuePc),
        .issueTag   (issueTag),
        .rsFull     (rsFull),
        .resultValid(resultValid),
        .resultTag  (resultTag),
        .resultData (resultData)
    );

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
    end

    task automatic stopWithFailure(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic checkResult();
        int latency;
        assert (!cancelled[resultTag]) else begin
            stopWithFailure($sformatf("Result at %0t carries tag %0d of a flushed instruction.",
                $time, resultTag));
        end
        assert (outstanding[resultTag]) else begin
            stopWithFailure($sformatf("Result at %0t carries tag %0d, which is not outstanding.",
                $time, resultTag));
        end
        assert (resultData == expData[resultTag]) else begin
            stopWithFailure($sformatf("FAILED at %0t: resultData (tag %0d) got %h expected %h",
                $time, resultTag, resultData, expData[resultTag]));
        end
        latency = cycleCount - issueCycle[resultTag];
        // Zero means the latency depends on other entries.
        if (expLat[resultTag] != 0) begin
            assert (latency == expLat[resultTag]) else begin
                stopWithFailure($sformatf(
                    "FAILED at %0t: resultValid latency (tag %0d) got %0d expected %0d",
                    $time, resultTag, latency, expLat[resultTag]));
            end
        end
        outstanding[resultTag] = 1'b0;
        outstandingCount--;
    endtask

    task automatic recordIssue();
        assert (!outstanding[issueTag]) else begin
            stopWithFailure($sformatf("Stim file reuses tag %0d while it is still outstanding.",
                issueTag));
        end
        outstanding[issueTag] = 1'b1;
        cancelled[issueTag] = 1'b0;
        expData[issueTag] = pendExp;
        expLat[issueTag] = pendLat;
        // Written at the coming edge.
        issueCycle[issueTag] = cycleCount + 1;
        outstandingCount++;
    endtask

    // Outputs sampled at the falling edge.
    always @(negedge clk) begin
        if (rstN) begin
            if (rsFull) begin
                sawFull = 1'b1;
            end
            if (resultValid) begin
                checkResult();
            end
            if (flush) begin
                cancelled = cancelled | outstanding;
                outstanding = '0;
                outstandingCount = 0;
            end else if (issueValid) begin
                recordIssue();
            end
        end
    end

    task automatic issueRecord();
        int waited;
        waited = 0;
        while (rsFull) begin
            assert (waited < WaitLimit) else begin
                stopWithFailure("Timed out waiting for rsFull to drop before an issue.");
            end
            @(posedge clk);
            #1;
            waited++;
        end
        pendExp = recExp;
        pendLat = recLat;
        issueOp = recOp;
        issueV1 = recV1;
        issueV2 = recV2;
        issueQ1 = recQ1;
        issueQ2 = recQ2;
        issueImm = recImm;
        issuePc = recPc;
        issueTag = recTag;
        issueValid = 1'b1;
        @(posedge clk);
        #1;
        issueValid = 1'b0;
    endtask

    task automatic flushCluster();
        flush = 1'b1;
        @(posedge clk);
        #1;
        flush = 1'b0;
        assert (!resultValid) else begin
            stopWithFailure($sformatf("FAILED at %0t: resultValid got %b expected 0",
                $time, resultValid));
        end
        assert (!rsFull) else begin
            stopWithFailure($sformatf("FAILED at %0t: rsFull got %b expected 0", $time, rsFull));
        end
    endtask

    task automatic drainAll();
        int waited;
        waited = 0;
        while (outstandingCount != 0) begin
            assert (waited < WaitLimit) else begin
                stopWithFailure($sformatf("Drain timed out with %0d results still outstanding.",
                    outstandingCount));
            end
            @(posedge clk);
            #1;
            waited++;
        end
    endtask

    initial begin
        int fd;
        int code;
        int waited;
        logic done;
        logic [7:0] kind;
        logic [8*200-1:0] restLine;
        flush = 1'b0;
        issueValid = 1'b0;
        issueOp = '0;
        issueV1 = '0;
        issueV2 = '0;
        issueQ1 = '0;
        issueQ2 = '0;
        issueImm = '0;
        issuePc = '0;
        issueTag = '0;
        pendExp = '0;
        pendLat = 0;
        waited = 0;
        while (rstN !== 1'b1) begin
            assert (waited < WaitLimit) else begin
                stopWithFailure("Reset was never released.");
            end
            @(posedge clk);
            #1;
            waited++;
        end
        // Quiet outputs before any issue.
        for (int i = 0; i < 4; i++) begin
            @(posedge clk);
            #1;
            assert (!resultValid) else begin
                stopWithFailure($sformatf("FAILED at %0t: resultValid got %b expected 0",
                    $time, resultValid));
            end
            assert (!rsFull) else begin
                stopWithFailure($sformatf("FAILED at %0t: rsFull got %b expected 0",
                    $time, rsFull));
            end
        end
        fd = $fopen("sim/rsStim.txt", "r");
        assert (fd != 0) else begin
            stopWithFailure("Could not open sim/rsStim.txt.");
        end
        done = 1'b0;
        while (!done) begin
            code = $fscanf(fd, "%s", kind);
            if (code != 1) begin
                done = 1'b1;
            end else if (kind == "#") begin
                code = $fgets(restLine, fd);
            end else if (kind == "I") begin
                code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %d", recOp, recV1, recV2,
                    recQ1, recQ2, recImm, recPc, recTag, recExp, recLat);
                assert (code == 10) else begin
                    stopWithFailure("Malformed issue record in the stim file.");
                end
                issueRecord();
            end else if (kind == "F") begin
                flushCluster();
            end else if (kind == "D") begin
                drainAll();
            end else begin
                stopWithFailure("Unknown record kind in the stim file.");
            end
        end
        $fclose(fd);
        drainAll();
        if (sawFull) begin
            $display("TEST OK");
            $finish;
        end else begin
            stopWithFailure("rsFull never went high, so the station was never filled.");
        end
    end

endmodule

// File: sim/tbClock.sv
`timescale 1ns/1ps

module tbClock (
    output logic clk,
    output logic rstN
);

    // 4 ns period.
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Reset low for the first two rising edges.
    initial begin
        rstN = 1'b0;
        repeat (2) @(posedge clk);
        rstN <= 1'b1;
    end

endmodule

// File: design/execCluster.sv
`timescale 1ns/1ps

module execCluster (
    input  logic clk,
    input  logic rstN,
    input  logic flush,

    input  logic issueValid,
    input  logic [rsPkg::OpWidth-1:0] issueOp,
    input  logic [rsPkg::DataWidth-1:0] issueV1,
    input  logic [rsPkg::DataWidth-1:0] issueV2,
    input  logic [rsPkg::TagWidth-1:0] issueQ1,
    input  logic [rsPkg::TagWidth-1:0] issueQ2,
    input  logic [rsPkg::DataWidth-1:0] issueImm,
    input  logic [rsPkg::DataWidth-1:0] issuePc,
    input  logic [rsPkg::TagWidth-1:0] issueTag,

    output logic rsFull,
    output logic resultValid,
    output logic [rsPkg::TagWidth-1:0] resultTag,
    output logic [rsPkg::DataWidth-1:0] resultData
);

    // Station to ALU.
    logic aluValid;
    logic [rsPkg::OpWidth-1:0] aluOp;
    logic [rsPkg::DataWidth-1:0] aluV1;
    logic [rsPkg::DataWidth-1:0] aluV2;
    logic [rsPkg::DataWidth-1:0] aluImm;
    logic [rsPkg::DataWidth-1:0] aluPc;
    logic [rsPkg::TagWidth-1:0] aluTag;

    // The result broadcast also wakes up waiting entries.
    rsStation u_rsStation (
        .clk        (clk),
        .rstN       (rstN),
        .flush      (flush),
        .issueValid (issueValid),
        .issueOp    (issueOp),
        .issueV1    (issueV1),
        .issueV2    (issueV2),
        .issueQ1    (issueQ1),
        .issueQ2    (issueQ2),
        .issueImm   (issueImm),
        .issuePc    (issuePc),
        .issueTag   (issueTag),
        .resultValid(resultValid),
        .resultTag  (resultTag),
        .resultData (resultData),
        .rsFull     (rsFull),
        .aluValid   (aluValid),
        .aluOp      (aluOp),
        .aluV1      (aluV1),
        .aluV2      (aluV2),
        .aluImm     (aluImm),
        .aluPc      (aluPc),
        .aluTag     (aluTag)
    );

    intAlu u_intAlu (
        .clk        (clk),
        .rstN       (rstN),
        .flush      (flush),
        .aluValid   (aluValid),
        .aluOp      (aluOp),
        .aluV1      (aluV1),
        .aluV2      (aluV2),
        .aluImm     (aluImm),
        .aluPc      (aluPc),
        .aluTag     (aluTag),
        .resultValid(resultValid),
        .resultTag  (resultTag),
        .resultData (resultData)
    );

endmodule

// File: design/intAlu.sv
`timescale 1ns/1ps

module intAlu (
    input  logic clk,
    input  logic rstN,
    input  logic flush,

    input  logic aluValid,
    input  logic [rsPkg::OpWidth-1:0] aluOp,
    input  logic [rsPkg::DataWidth-1:0] aluV1,
    input  logic [rsPkg::DataWidth-1:0] aluV2,
    input  logic [rsPkg::DataWidth-1:0] aluImm,
    input  logic [rsPkg::DataWidth-1:0] aluPc,
    input  logic [rsPkg::TagWidth-1:0] aluTag,

    output logic resultValid,
    output logic [rsPkg::TagWidth-1:0] resultTag,
    output logic [rsPkg::DataWidth-1:0] resultData
);

    logic [rsPkg::DataWidth-1:0] aluResult;
    logic [rsPkg::ShamtWidth-1:0] shamt;
    logic lessThan;

    assign shamt = aluV2[rsPkg::ShamtWidth-1:0];
    assign lessThan = $signed(aluV1) < $signed(aluV2);

    always_comb begin
        case (aluOp)
            rsPkg::OpAdd: aluResult = aluV1 + aluV2;
            rsPkg::OpSub: aluResult = aluV1 - aluV2;
            rsPkg::OpAnd: aluResult = aluV1 & aluV2;
            rsPkg::OpOr: aluResult = aluV1 | aluV2;
            rsPkg::OpXor: aluResult = aluV1 ^ aluV2;
            rsPkg::OpSll: aluResult = aluV1 << shamt;
            rsPkg::OpSrl: aluResult = aluV1 >> shamt;
            rsPkg::OpSlt: aluResult = {{(rsPkg::DataWidth - 1){1'b0}}, lessThan};
            rsPkg::OpAddi: aluResult = aluV1 + aluImm;
            rsPkg::OpAuipc: aluResult = aluPc + aluImm;
            // Unknown codes give zero.
            default: aluResult = '0;
        endcase
    end

    // Flush cancels the instruction in this stage.
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            resultValid <= 1'b0;
        end else if (flush) begin
            resultValid <= 1'b0;
        end else begin
            resultValid <= aluValid;
        end
    end

    always_ff @(posedge clk) begin
        if (aluValid) begin
            resultTag <= aluTag;
            resultData <= aluResult;
        end
    end

endmodule

// File: design/rsStation.sv
`timescale 1ns/1ps

module rsStation (
    input  logic clk,
    input  logic rstN,
    input  logic flush,

    input  logic issueValid,
    input  logic [rsPkg::OpWidth-1:0] issueOp,
    input  logic [rsPkg::DataWidth-1:0] issueV1,
    input  logic [rsPkg::DataWidth-1:0] issueV2,
    input  logic [rsPkg::TagWidth-1:0] issueQ1,
    input  logic [rsPkg::TagWidth-1:0] issueQ2,
    input  logic [rsPkg::DataWidth-1:0] issueImm,
    input  logic [rsPkg::DataWidth-1:0] issuePc,
    input  logic [rsPkg::TagWidth-1:0] issueTag,

    input  logic resultValid,
    input  logic [rsPkg::TagWidth-1:0] resultTag,
    input  logic [rsPkg::DataWidth-1:0] resultData,

    output logic rsFull,

    output logic aluValid,
    output logic [rsPkg::OpWidth-1:0] aluOp,
    output logic [rsPkg::DataWidth-1:0] aluV1,
    output logic [rsPkg::DataWidth-1:0] aluV2,
    output logic [rsPkg::DataWidth-1:0] aluImm,
    output logic [rsPkg::DataWidth-1:0] aluPc,
    output logic [rsPkg::TagWidth-1:0] aluTag
);

    // Entry storage.
    logic [rsPkg::RsDepth-1:0] busy;
    logic [rsPkg::OpWidth-1:0] entOp [rsPkg::RsDepth];
    logic [rsPkg::DataWidth-1:0] entV1 [rsPkg::RsDepth];
    logic [rsPkg::DataWidth-1:0] entV2 [rsPkg::RsDepth];
    logic [rsPkg::TagWidth-1:0] entQ1 [rsPkg::RsDepth];
    logic [rsPkg::TagWidth-1:0] entQ2 [rsPkg::RsDepth];
    logic [rsPkg::DataWidth-1:0] entImm [rsPkg::RsDepth];
    logic [rsPkg::DataWidth-1:0] entPc [rsPkg::RsDepth];
    logic [rsPkg::TagWidth-1:0] entTag [rsPkg::RsDepth];

    // Wakeup and select.
    logic [rsPkg::RsDepth-1:0] wake1;
    logic [rsPkg::RsDepth-1:0] wake2;
    logic [rsPkg::RsDepth-1:0] readyVec;
    logic selValid;
    logic [rsPkg::RsIdxWidth-1:0] selIdx;

    // Allocation.
    logic freeValid;
    logic [rsPkg::RsIdxWidth-1:0] freeIdx;
    logic doWrite;
    logic [rsPkg::RsDepth-1:0] busyNext;

    // Operands of the incoming instruction after a same-cycle broadcast.
    logic hit1;
    logic hit2;
    logic [rsPkg::DataWidth-1:0] newV1;
    logic [rsPkg::DataWidth-1:0] newV2;
    logic [rsPkg::TagWidth-1:0] newQ1;
    logic [rsPkg::TagWidth-1:0] newQ2;

    assign rsFull = &busy;

    always_comb begin
        for (int i = 0; i < rsPkg::RsDepth; i++) begin
            wake1[i] = resultValid && busy[i] && (entQ1[i] != rsPkg::TagNone)
                && (entQ1[i] == resultTag);
            wake2[i] = resultValid && busy[i] && (entQ2[i] != rsPkg::TagNone)
                && (entQ2[i] == resultTag);
            readyVec[i] = busy[i] && (entQ1[i] == rsPkg::TagNone)
                && (entQ2[i] == rsPkg::TagNone);
        end
    end

    // Lowest-indexed ready entry wins.
    always_comb begin
        selValid = 1'b0;
        selIdx = '0;
        for (int i = rsPkg::RsDepth - 1; i >= 0; i--) begin
            if (readyVec[i]) begin
                selValid = 1'b1;
                selIdx = i[rsPkg::RsIdxWidth-1:0];
            end
        end
    end

    // Lowest-indexed free entry taken from the registered busy bits only.
    always_comb begin
        freeValid = 1'b0;
        freeIdx = '0;
        for (int i = rsPkg::RsDepth - 1; i >= 0; i--) begin
            if (!busy[i]) begin
                freeValid = 1'b1;
                freeIdx = i[rsPkg::RsIdxWidth-1:0];
            end
        end
    end

    // A strobe while full is dropped.
    assign doWrite = issueValid && freeValid;

    // Catch a producer broadcasting in the same cycle as the issue.
    assign hit1 = resultValid && (issueQ1 != rsPkg::TagNone) && (issueQ1 == resultTag);
    assign hit2 = resultValid && (issueQ2 != rsPkg::TagNone) && (issueQ2 == resultTag);
    assign newV1 = hit1 ? resultData : issueV1;
    assign newV2 = hit2 ? resultData : issueV2;
    assign newQ1 = hit1 ? rsPkg::TagNone : issueQ1;
    assign newQ2 = hit2 ? rsPkg::TagNone : issueQ2;

    always_comb begin
        busyNext = busy;
        if (selValid) begin
            busyNext[selIdx] = 1'b0;
        end
        if (doWrite) begin
            busyNext[freeIdx] = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            busy <= '0;
            aluValid <= 1'b0;
        end else if (flush) begin
            busy <= '0;
            aluValid <= 1'b0;
        end else begin
            busy <= busyNext;
            aluValid <= selValid;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < rsPkg::RsDepth; i++) begin
            if (doWrite && (freeIdx == i[rsPkg::RsIdxWidth-1:0])) begin
                entOp[i] <= issueOp;
                entV1[i] <= newV1;
                entV2[i] <= newV2;
                entQ1[i] <= newQ1;
                entQ2[i] <= newQ2;
                entImm[i] <= issueImm;
                entPc[i] <= issuePc;
                entTag[i] <= issueTag;
            end else begin
                // Both operands may wait on the same tag.
                if (wake1[i]) begin
                    entV1[i] <= resultData;
                    entQ1[i] <= rsPkg::TagNone;
                end
                if (wake2[i]) begin
                    entV2[i] <= resultData;
                    entQ2[i] <= rsPkg::TagNone;
                end
            end
        end
    end

    // Issue register.
    always_ff @(posedge clk) begin
        if (selValid) begin
            aluOp <= entOp[selIdx];
            aluV1 <= entV1[selIdx];
            aluV2 <= entV2[selIdx];
            aluImm <= entImm[selIdx];
            aluPc <= entPc[selIdx];
            aluTag <= entTag[selIdx];
        end
    end

endmodule

// File: design/rsPkg.sv
package rsPkg;

    // Datapath and tag widths.
    localparam int unsigned DataWidth = 32;
    localparam int unsigned TagWidth = 4;
    localparam int unsigned OpWidth = 4;

    // Shift amount taken from the low bits of v2.
    localparam int unsigned ShamtWidth = 5;

    // Station depth and entry index width.
    localparam int unsigned RsDepth = 8;
    localparam int unsigned RsIdxWidth = (RsDepth > 1) ? $clog2(RsDepth) : 1;

    // Tag zero marks an operand whose value is present.
    localparam logic [TagWidth-1:0] TagNone = '0;

    // Register-register operations.
    localparam logic [OpWidth-1:0] OpAdd = 4'd0;
    localparam logic [OpWidth-1:0] OpSub = 4'd1;
    localparam logic [OpWidth-1:0] OpAnd = 4'd2;
    localparam logic [OpWidth-1:0] OpOr = 4'd3;
    localparam logic [OpWidth-1:0] OpXor = 4'd4;
    localparam logic [OpWidth-1:0] OpSll = 4'd5;
    localparam logic [OpWidth-1:0] OpSrl = 4'd6;
    localparam logic [OpWidth-1:0] OpSlt = 4'd7;

    // Immediate forms.
    localparam logic [OpWidth-1:0] OpAddi = 4'd8;
    localparam logic [OpWidth-1:0] OpAuipc = 4'd9;

endpackage
